//--- hdl/rvCore_defines.svh
// ISA widths, opcode fields, ALU control codes and the reset instruction
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define WORD_ADDR_W 30

// Opcode field inst[6:2]
`define OPC_RTYPE   5'b01100
`define OPC_ITYPE   5'b00100
`define OPC_LOAD    5'b00000
`define OPC_STORE   5'b01000
`define OPC_BRANCH  5'b11000

// ALU control is {func7 bit, func3} for register ops
`define ALU_ADD     4'b0000
`define ALU_SUB     4'b1000
`define ALU_SLT     4'b0010
`define ALU_XOR     4'b0100
`define ALU_OR      4'b0110
`define ALU_AND     4'b0111
`define ALU_SLL     4'b0001
`define ALU_SRL     4'b0101
`define ALU_SRA     4'b1101

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

`endif

//--- hdl/rvCorePkg.sv
// Width typedefs, control bundle and pipeline register structs of the core
`default_nettype none

`include "rvCore_defines.svh"

package rvCorePkg;

    typedef logic [`XLEN-1:0]        word_t;
    typedef logic [`REG_ADDR_W-1:0]  regAddr_t;
    typedef logic [`WORD_ADDR_W-1:0] wordAddr_t;
    typedef logic [3:0]              aluCtrl_t;

    // Bit 1 takes the memory stage, bit 0 takes writeback
    typedef logic [1:0] fwdSel_t;

    // All zero is a bubble
    typedef struct packed {
        logic       regWrite;
        logic       memToReg;
        logic       branch;
        logic       memRead;
        logic       memWrite;
        logic       aluSrc;
        logic [1:0] aluOp;
    } ctrlBundle_t;

    typedef struct packed {
        wordAddr_t pc;
        word_t     inst;
    } ifIdReg_t;

    typedef struct packed {
        ctrlBundle_t ctrl;
        wordAddr_t   pc;
        regAddr_t    rs1;
        regAddr_t    rs2;
        regAddr_t    rd;
        word_t       rdata1;
        word_t       rdata2;
        word_t       imm;
        logic [2:0]  func3;
        logic        func7;
    } idExReg_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        logic     memRead;
        logic     memWrite;
        word_t    aluOut;
        word_t    storeData;
        regAddr_t rd;
    } exMemReg_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        word_t    aluOut;
        word_t    loadData;
        regAddr_t rd;
    } memWbReg_t;

endpackage

`default_nettype wire

//--- hdl/regFile.sv
// Integer register file, two read ports and one write port, x0 hardwired to zero
`default_nettype none

`include "rvCore_defines.svh"

module regFile (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               wrEn,
    input  wire rvCorePkg::regAddr_t wrAddr,
    input  wire rvCorePkg::word_t    wrData,
    input  wire rvCorePkg::regAddr_t rdAddrA,
    input  wire rvCorePkg::regAddr_t rdAddrB,
    output rvCorePkg::word_t         rdDataA,
    output rvCorePkg::word_t         rdDataB
);
    import rvCorePkg::*;

    word_t regs [0:(2**`REG_ADDR_W)-1];

    // Entry 0 is cleared by reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

//--- hdl/decodeUnit.sv
// Main control decode and immediate generator for the supported RV32I subset
`default_nettype none

`include "rvCore_defines.svh"

module decodeUnit (
    input  wire rvCorePkg::word_t inst,
    output rvCorePkg::ctrlBundle_t ctrl,
    output rvCorePkg::word_t       imm
);
    logic [4:0] opcode;

    assign opcode = inst[6:2];

    //============================================================
    // Control bundle
    //============================================================
    // aluOp: 00 address add, 01 branch compare, 10 R-type, 11 I-type
    always_comb begin
        ctrl = '0;
        case (opcode)
            `OPC_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = 2'b10;
            end
            `OPC_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = 2'b11;
            end
            `OPC_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = 2'b00;
            end
            `OPC_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = 2'b00;
            end
            `OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = 2'b01;
            end
            default: begin
                // Unknown opcode leaves a bubble
                ctrl = '0;
            end
        endcase
    end

    //============================================================
    // Immediate generator
    //============================================================
    always_comb begin
        case (opcode)
            `OPC_ITYPE, `OPC_LOAD: begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            end
            `OPC_STORE: begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            `OPC_BRANCH: begin
                // Byte offset, bit 0 always zero
                imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
// Load-use stall detection and forwarding selects for execute and decode
`default_nettype none

module hazardUnit (
    input  wire rvCorePkg::regAddr_t idRs1,
    input  wire rvCorePkg::regAddr_t idRs2,
    input  wire rvCorePkg::regAddr_t exRs1,
    input  wire rvCorePkg::regAddr_t exRs2,
    input  wire rvCorePkg::regAddr_t exRd,
    input  wire rvCorePkg::regAddr_t memRd,
    input  wire rvCorePkg::regAddr_t wbRd,
    input  wire logic                exMemRead,
    input  wire logic                memRegWrite,
    input  wire logic                wbRegWrite,
    output logic                     loadUseStall,
    output rvCorePkg::fwdSel_t       fwdA,
    output rvCorePkg::fwdSel_t       fwdB,
    output logic                     idFwdA,
    output logic                     idFwdB
);
    import rvCorePkg::*;

    // Memory stage wins over writeback, x0 never forwards
    function automatic fwdSel_t exFwd(input regAddr_t src, input logic mWr,
                                      input regAddr_t mRd, input logic wWr,
                                      input regAddr_t wRd);
        logic fromMem;
        logic fromWb;
        fromMem = mWr && (mRd != '0) && (mRd == src);
        fromWb  = wWr && (wRd != '0) && (wRd == src) && !fromMem;
        return {fromMem, fromWb};
    endfunction

    always_comb begin
        fwdA   = exFwd(exRs1, memRegWrite, memRd, wbRegWrite, wbRd);
        fwdB   = exFwd(exRs2, memRegWrite, memRd, wbRegWrite, wbRd);
        // Same-cycle write seen by the register read in decode
        idFwdA = wbRegWrite && (wbRd != '0) && (wbRd == idRs1);
        idFwdB = wbRegWrite && (wbRd != '0) && (wbRd == idRs2);
        // Load in execute feeding the instruction in decode
        loadUseStall = exMemRead && (exRd != '0) &&
                       ((exRd == idRs1) || (exRd == idRs2));
    end

endmodule

`default_nettype wire

//--- hdl/executeUnit.sv
// Execute stage: ALU control, operand forwarding, ALU, branch compare and target
`default_nettype none

`include "rvCore_defines.svh"

module executeUnit (
    input  wire rvCorePkg::idExReg_t idEx,
    input  wire rvCorePkg::fwdSel_t  fwdA,
    input  wire rvCorePkg::fwdSel_t  fwdB,
    input  wire rvCorePkg::word_t    memAluOut,
    input  wire rvCorePkg::word_t    wbData,
    output rvCorePkg::word_t         aluOut,
    output rvCorePkg::word_t         storeData,
    output logic                     branchTaken,
    output rvCorePkg::wordAddr_t     branchTarget
);
    import rvCorePkg::*;

    aluCtrl_t   aluCtrl;
    word_t      opA;
    word_t      opBReg;
    word_t      opB;
    logic [4:0] shamt;

    // ALU control from aluOp, func3 and the func7 bit
    always_comb begin
        case (idEx.ctrl.aluOp)
            2'b00: aluCtrl = `ALU_ADD;
            2'b01: aluCtrl = `ALU_SUB;
            2'b10: aluCtrl = {idEx.func7, idEx.func3};
            // Only srai keeps the func7 bit, otherwise it is an immediate bit
            default: aluCtrl = (idEx.func3 == 3'b101 && idEx.func7) ? `ALU_SRA
                                                                    : {1'b0, idEx.func3};
        endcase
    end

    // Forwarding muxes
    assign opA    = fwdA[1] ? memAluOut : (fwdA[0] ? wbData : idEx.rdata1);
    assign opBReg = fwdB[1] ? memAluOut : (fwdB[0] ? wbData : idEx.rdata2);
    assign opB    = idEx.ctrl.aluSrc ? idEx.imm : opBReg;
    assign shamt  = opB[4:0];

    //============================================================
    // ALU
    //============================================================
    always_comb begin
        case (aluCtrl)
            `ALU_ADD: aluOut = opA + opB;
            `ALU_SUB: aluOut = opA - opB;
            `ALU_SLT: aluOut = {{(`XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
            `ALU_XOR: aluOut = opA ^ opB;
            `ALU_OR:  aluOut = opA | opB;
            `ALU_AND: aluOut = opA & opB;
            `ALU_SLL: aluOut = opA << shamt;
            `ALU_SRL: aluOut = opA >> shamt;
            `ALU_SRA: aluOut = $signed(opA) >>> shamt;
            default:  aluOut = '0;
        endcase
    end

    // Branch compare on the subtract result, func3[0] picks bne
    assign branchTaken  = idEx.ctrl.branch &&
                          (idEx.func3[0] ? (aluOut != '0) : (aluOut == '0));
    assign branchTarget = idEx.pc + idEx.imm[`XLEN-1:2];

    // Data cache expects byte 0 in the top lane
    assign storeData = {<<8{opBReg}};

endmodule

`default_nettype wire

//--- hdl/rvPipeline.sv
// Five-stage RV32I pipeline top with pc, stage registers, flush, freeze and cache ports
`default_nettype none

`include "rvCore_defines.svh"

module rvPipeline (
    input  wire logic                clk,
    input  wire logic                rst_n,
    output logic                     iCacheRen,
    output rvCorePkg::wordAddr_t     iCacheAddr,
    input  wire logic                iCacheStall,
    input  wire rvCorePkg::word_t    iCacheRdata,
    output logic                     dCacheRen,
    output logic                     dCacheWen,
    output rvCorePkg::wordAddr_t     dCacheAddr,
    output rvCorePkg::word_t         dCacheWdata,
    input  wire logic                dCacheStall,
    input  wire rvCorePkg::word_t    dCacheRdata
);
    import rvCorePkg::*;

    wordAddr_t   pc, pcNext;
    ifIdReg_t    ifId, ifIdNext;
    idExReg_t    idEx, idExNext;
    exMemReg_t   exMem, exMemNext;
    memWbReg_t   memWb, memWbNext;

    ctrlBundle_t decCtrl;
    word_t       decImm;
    word_t       rdDataA, rdDataB;
    word_t       wbData;
    word_t       exAluOut, exStoreData;
    wordAddr_t   branchTarget;
    fwdSel_t     fwdA, fwdB;
    logic        idFwdA, idFwdB;
    logic        loadUseStall;
    logic        branchTaken;
    logic        freeze;

    // Either cache stalling holds the whole core
    assign freeze = iCacheStall | dCacheStall;
    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluOut;

    //============================================================
    // Stage logic
    //============================================================
    regFile i_regFile (
        .clk     (clk),
        .rst_n   (rst_n),
        .wrEn    (memWb.regWrite & ~freeze),
        .wrAddr  (memWb.rd),
        .wrData  (wbData),
        .rdAddrA (ifId.inst[19:15]),
        .rdAddrB (ifId.inst[24:20]),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    decodeUnit i_decodeUnit (
        .inst (ifId.inst),
        .ctrl (decCtrl),
        .imm  (decImm)
    );

    hazardUnit i_hazardUnit (
        .idRs1        (ifId.inst[19:15]),
        .idRs2        (ifId.inst[24:20]),
        .exRs1        (idEx.rs1),
        .exRs2        (idEx.rs2),
        .exRd         (idEx.rd),
        .memRd        (exMem.rd),
        .wbRd         (memWb.rd),
        .exMemRead    (idEx.ctrl.memRead),
        .memRegWrite  (exMem.regWrite),
        .wbRegWrite   (memWb.regWrite),
        .loadUseStall (loadUseStall),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .idFwdA       (idFwdA),
        .idFwdB       (idFwdB)
    );

    executeUnit i_executeUnit (
        .idEx         (idEx),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .memAluOut    (exMem.aluOut),
        .wbData       (wbData),
        .aluOut       (exAluOut),
        .storeData    (exStoreData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    // Next values, branch and load-use never coincide in execute
    always_comb begin
        pcNext = branchTaken ? branchTarget : (loadUseStall ? pc : pc + 1'b1);

        ifIdNext.pc   = pc;
        ifIdNext.inst = {<<8{iCacheRdata}};
        if (branchTaken) begin
            ifIdNext.inst = `NOP_INST;
        end else if (loadUseStall) begin
            ifIdNext = ifId;
        end

        idExNext.ctrl   = (branchTaken || loadUseStall) ? '0 : decCtrl;
        idExNext.pc     = ifId.pc;
        idExNext.rs1    = ifId.inst[19:15];
        idExNext.rs2    = ifId.inst[24:20];
        idExNext.rd     = ifId.inst[11:7];
        idExNext.rdata1 = idFwdA ? wbData : rdDataA;
        idExNext.rdata2 = idFwdB ? wbData : rdDataB;
        idExNext.imm    = decImm;
        idExNext.func3  = ifId.inst[14:12];
        idExNext.func7  = ifId.inst[30];

        exMemNext = '{regWrite: idEx.ctrl.regWrite, memToReg: idEx.ctrl.memToReg,
                      memRead: idEx.ctrl.memRead, memWrite: idEx.ctrl.memWrite,
                      aluOut: exAluOut, storeData: exStoreData, rd: idEx.rd};

        memWbNext = '{regWrite: exMem.regWrite, memToReg: exMem.memToReg,
                      aluOut: exMem.aluOut, loadData: {<<8{dCacheRdata}}, rd: exMem.rd};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            ifId  <= '{pc: '0, inst: `NOP_INST};
            idEx  <= '0;
            exMem <= '0;
            memWb <= '0;
        end else if (!freeze) begin
            pc    <= pcNext;
            ifId  <= ifIdNext;
            idEx  <= idExNext;
            exMem <= exMemNext;
            memWb <= memWbNext;
        end
    end

    // Cache ports
    assign iCacheRen   = 1'b1;
    assign iCacheAddr  = pc;
    assign dCacheRen   = exMem.memRead;
    // Store held by an instruction-side stall is written only once
    assign dCacheWen   = exMem.memWrite & ~iCacheStall;
    assign dCacheAddr  = exMem.aluOut[`XLEN-1:2];
    assign dCacheWdata = exMem.storeData;

endmodule

`default_nettype wire

//--- sim/tbClock.sv
// Free-running testbench clock with a period of 40 time units
`default_nettype none

module tbClock (
    output logic clk
);
    initial clk = 1'b0;

    always #20 clk = ~clk;

endmodule

`default_nettype wire

//--- sim/rvPipelineTb.sv
// Pipeline testbench: program image, cache models, stall stimulus, store checker, timeout
`default_nettype none

`include "rvCore_defines.svh"

module rvPipelineTb;
    import rvCorePkg::*;

    localparam int NUM_STORES = 19;
    localparam int PROG_WORDS = 64;
    // Two runs of roughly 100 cycles each, random stalls at most triple the second
    localparam int TIMEOUT_CYCLES = 3000;

    logic        clk;
    logic        rst_n;
    logic        iCacheRen;
    wordAddr_t   iCacheAddr;
    logic        iCacheStall;
    word_t       iCacheRdata;
    logic        dCacheRen;
    logic        dCacheWen;
    wordAddr_t   dCacheAddr;
    word_t       dCacheWdata;
    logic        dCacheStall;
    word_t       dCacheRdata;

    word_t       imem [0:PROG_WORDS-1];
    word_t       dmem [0:63];
    wordAddr_t   expAddr [0:NUM_STORES-1];
    word_t       expData [0:NUM_STORES-1];
    int          progLen;
    int          storeIdx;
    int          cycleCount;
    int          seed;
    logic [31:0] stallBits;
    logic        stallPhase;
    logic        prevDStall;
    wordAddr_t   prevAddr;
    word_t       prevWdata;

    tbClock i_tbClock (.clk(clk));

    rvPipeline i_rvPipeline (
        .clk         (clk),
        .rst_n       (rst_n),
        .iCacheRen   (iCacheRen),
        .iCacheAddr  (iCacheAddr),
        .iCacheStall (iCacheStall),
        .iCacheRdata (iCacheRdata),
        .dCacheRen   (dCacheRen),
        .dCacheWen   (dCacheWen),
        .dCacheAddr  (dCacheAddr),
        .dCacheWdata (dCacheWdata),
        .dCacheStall (dCacheStall),
        .dCacheRdata (dCacheRdata)
    );

    function automatic word_t swapBytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    //============================================================
    // Instruction encoders
    //============================================================
    function automatic word_t rType(input logic f7, input regAddr_t rs2, input regAddr_t rs1,
                                    input logic [2:0] f3, input regAddr_t rd);
        return {1'b0, f7, 5'b0, rs2, rs1, f3, rd, `OPC_RTYPE, 2'b11};
    endfunction

    function automatic word_t iType(input logic [11:0] imm, input regAddr_t rs1,
                                    input logic [2:0] f3, input regAddr_t rd);
        return {imm, rs1, f3, rd, `OPC_ITYPE, 2'b11};
    endfunction

    function automatic word_t loadWord(input logic [11:0] imm, input regAddr_t rs1,
                                       input regAddr_t rd);
        return {imm, rs1, 3'b010, rd, `OPC_LOAD, 2'b11};
    endfunction

    function automatic word_t sType(input logic [11:0] imm, input regAddr_t rs2,
                                    input regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE, 2'b11};
    endfunction

    function automatic word_t bType(input logic [12:0] imm, input regAddr_t rs2,
                                    input regAddr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH, 2'b11};
    endfunction

    task automatic putInst(input word_t inst);
        imem[progLen] = swapBytes(inst);
        progLen++;
    endtask

    task automatic loadProgram();
        putInst(iType(12'd100, 0, 3'b000, 1));
        putInst(iType(12'hFF9, 0, 3'b000, 2));
        putInst(rType(1'b0, 2, 1, 3'b000, 3));
        putInst(sType(12'd64, 3, 0));
        putInst(rType(1'b1, 1, 2, 3'b000, 4));
        putInst(sType(12'd68, 4, 0));
        putInst(rType(1'b0, 1, 2, 3'b010, 5));
        putInst(rType(1'b0, 2, 1, 3'b010, 6));
        putInst(sType(12'd72, 5, 0));
        putInst(sType(12'd76, 6, 0));
        // Dependent chain through memory and writeback forwarding
        putInst(rType(1'b0, 2, 1, 3'b100, 7));
        putInst(rType(1'b0, 1, 7, 3'b110, 8));
        putInst(rType(1'b0, 7, 8, 3'b111, 9));
        putInst(sType(12'd80, 7, 0));
        putInst(sType(12'd84, 8, 0));
        putInst(sType(12'd88, 9, 0));
        putInst(rType(1'b0, 5, 1, 3'b001, 12));
        putInst(rType(1'b0, 5, 2, 3'b101, 13));
        putInst(rType(1'b1, 5, 2, 3'b101, 14));
        putInst(sType(12'd92, 12, 0));
        putInst(sType(12'd96, 13, 0));
        putInst(sType(12'd100, 14, 0));
        putInst(iType(12'd4, 1, 3'b001, 15));
        putInst(iType(12'd28, 2, 3'b101, 16));
        putInst(iType(12'h402, 2, 3'b101, 17));
        putInst(sType(12'd104, 15, 0));
        putInst(sType(12'd108, 16, 0));
        putInst(sType(12'd112, 17, 0));
        putInst(iType(12'hFFA, 2, 3'b010, 18));
        putInst(iType(12'h0F0, 1, 3'b100, 19));
        putInst(iType(12'hF00, 1, 3'b110, 20));
        putInst(iType(12'h07F, 2, 3'b111, 21));
        putInst(sType(12'd116, 18, 0));
        putInst(sType(12'd120, 19, 0));
        putInst(sType(12'd124, 20, 0));
        putInst(sType(12'd128, 21, 0));
        // Load-use pair
        putInst(loadWord(12'd16, 0, 10));
        putInst(rType(1'b0, 1, 10, 3'b000, 11));
        putInst(sType(12'd132, 11, 0));
        // Taken beq and bne each skip two stores, then a not-taken beq
        putInst(bType(13'd12, 5, 5, 3'b000));
        putInst(sType(12'd136, 1, 0));
        putInst(sType(12'd140, 1, 0));
        putInst(bType(13'd12, 2, 1, 3'b001));
        putInst(sType(12'd136, 2, 0));
        putInst(sType(12'd140, 2, 0));
        putInst(bType(13'd8, 2, 1, 3'b000));
        putInst(sType(12'd144, 3, 0));
        putInst(bType(13'd0, 0, 0, 3'b000));
    endtask

    task automatic loadExpected();
        expData = '{32'h0000_005D, 32'hFFFF_FF95, 32'h0000_0001, 32'h0000_0000,
                    32'hFFFF_FF9D, 32'hFFFF_FFFD, 32'hFFFF_FF9D, 32'h0000_00C8,
                    32'h7FFF_FFFC, 32'hFFFF_FFFC, 32'h0000_0640, 32'h0000_000F,
                    32'hFFFF_FFFE, 32'h0000_0001, 32'h0000_0094, 32'hFFFF_FF64,
                    32'h0000_0079, 32'h1357_0468, 32'h0000_005D};
        for (int i = 0; i < NUM_STORES - 1; i++) begin
            expAddr[i] = wordAddr_t'(16 + i);
        end
        expAddr[NUM_STORES-1] = wordAddr_t'(36);
    endtask

    task automatic checkEqual(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    //============================================================
    // Cache models
    //============================================================
    // Past the program end the fetch port returns a nop
    assign iCacheRdata = (iCacheAddr < progLen) ? imem[iCacheAddr[5:0]]
                                                : swapBytes(`NOP_INST);
    assign dCacheRdata = dmem[dCacheAddr[5:0]];

    always @(posedge clk) begin
        if (dCacheWen && !dCacheStall) begin
            dmem[dCacheAddr[5:0]] <= dCacheWdata;
        end
    end

    // Stall stimulus, random only in the second run
    always @(posedge clk) begin
        #1;
        stallBits   = $random(seed);
        iCacheStall = stallPhase && (stallBits[1:0] == 2'b00);
        dCacheStall = stallPhase && (stallBits[3:2] == 2'b00);
    end

    //============================================================
    // Store checker and timeout
    //============================================================
    always @(negedge clk) begin
        // Fetch port reads every cycle
        if (rst_n) begin
            checkEqual("iCacheRen", 32'(iCacheRen), 32'h1);
        end
        if (rst_n && dCacheWen && !dCacheStall) begin
            assert (storeIdx < NUM_STORES) else begin
                $display("Unexpected extra store to word address %h", dCacheAddr);
                $display("RESULT: FAIL");
                $fatal(1);
            end
            checkEqual("dCacheAddr", 32'(dCacheAddr), 32'(expAddr[storeIdx]));
            checkEqual("dCacheWdata", swapBytes(dCacheWdata), expData[storeIdx]);
            storeIdx++;
        end
        // Outputs must hold across a data cache stall
        if (rst_n && prevDStall) begin
            checkEqual("dCacheAddr", 32'(dCacheAddr), 32'(prevAddr));
            checkEqual("dCacheWdata", dCacheWdata, prevWdata);
        end
        prevDStall = dCacheStall;
        prevAddr   = dCacheAddr;
        prevWdata  = dCacheWdata;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d stores seen",
                     cycleCount, storeIdx, NUM_STORES);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic applyReset(input logic withStalls);
        @(negedge clk);
        stallPhase = 1'b0;
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        storeIdx = 0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        checkEqual("iCacheAddr", 32'(iCacheAddr), 32'h0);
        checkEqual("dCacheRen", 32'(dCacheRen), 32'h0);
        checkEqual("dCacheWen", 32'(dCacheWen), 32'h0);
        stallPhase = withStalls;
        @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // Drain extra cycles in the self-loop to catch stray stores
    task automatic waitForStores();
        while (storeIdx < NUM_STORES) begin
            @(posedge clk);
        end
        repeat (30) @(posedge clk);
    endtask

    initial begin
        rst_n       = 1'b0;
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        stallPhase  = 1'b0;
        prevDStall  = 1'b0;
        prevAddr    = '0;
        prevWdata   = '0;
        seed        = 20857;
        storeIdx    = 0;
        cycleCount  = 0;
        progLen     = 0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = swapBytes(32'h1357_0000 + i * 32'h0000_0101);
        end
        loadProgram();
        loadExpected();

        applyReset(1'b0);
        waitForStores();
        // Same program again under random cache stalls
        applyReset(1'b1);
        waitForStores();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
hdl/rvCorePkg.sv
hdl/regFile.sv
hdl/decodeUnit.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/rvPipeline.sv
sim/tbClock.sv
sim/rvPipelineTb.sv

//--- Makefile
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= rvPipelineTb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
